//--- design/smc_pkg.sv
// Size codes, access states and the host request and external bus structs
`default_nettype none

package smc_pkg;

   // ------------------------------------------------------------------------
   // Size codes
   // ------------------------------------------------------------------------

   // Transfer size of one host request
   typedef enum logic [1:0]
   {
      XSIZ_8  = 2'b00,            // Byte
      XSIZ_16 = 2'b01,            // Halfword
      XSIZ_32 = 2'b10             // Word
   } xfer_size_t;

   // Width of the external data bus, a static level
   typedef enum logic [1:0]
   {
      BSIZ_8  = 2'b00,            // 8 bit memory
      BSIZ_16 = 2'b01,            // 16 bit memory
      BSIZ_32 = 2'b10             // 32 bit memory
   } bus_size_t;

   // Access state machine
   typedef enum logic [1:0]
   {
      SMC_IDLE = 2'b00,           // No transfer in flight
      SMC_RW   = 2'b01,           // Chip select low, wait states running
      SMC_TURN = 2'b10            // One idle cycle between accesses
   } smc_state_e;

   // ------------------------------------------------------------------------
   // Bundles
   // ------------------------------------------------------------------------

   // Host request, sampled in the valid_access cycle only
   typedef struct packed
   {
      logic       valid_access;   // Single cycle strobe
      logic       write;          // 1 for write, 0 for read
      logic       cs;             // Chip select
      xfer_size_t xfer_size;
      logic [31:0] addr;
      logic [31:0] wdata;         // Bytes sit on their address lanes
   } smc_req_t;

   // Registered outputs to the external memory
   typedef struct packed
   {
      logic [31:0] smc_addr;
      logic [3:0]  smc_n_be;      // Active low byte enables
      logic        smc_n_cs;      // Active low chip select
      logic        smc_n_we;      // Active low write enable
      logic [31:0] smc_wdata;
   } smc_ext_t;

endpackage

`default_nettype wire

//--- design/smc_access_ctrl.sv
// Access FSM with wait-state timer, access counter, size hold and busy
`default_nettype none

module smc_access_ctrl
#(
   parameter int WAIT_STATES = 1                 // Extra cycles per access
)
(
   input  wire                     sys_clk29,
   input  wire                     n_sys_reset29,
   input  wire                     valid_access,  // Start of a host transfer
   input  wire                     cs,
   input  smc_pkg::xfer_size_t     xfer_size,
   input  smc_pkg::bus_size_t      bus_size,
   output smc_pkg::smc_state_e     smc_nextstate,
   output logic                    smc_done,      // Last cycle of an access
   output logic [1:0]              r_num_access,  // Accesses still to come
   output smc_pkg::xfer_size_t     v_xfer_size,
   output smc_pkg::bus_size_t      v_bus_size,
   output logic                    busy
);

   import smc_pkg::*;

   // Timer wide enough to count up to WAIT_STATES
   localparam int WS_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
   localparam logic [WS_W-1:0] WS_LAST = WS_W'(WAIT_STATES);

   smc_state_e      r_state;
   logic [WS_W-1:0] r_wait_cnt;      // Cycles spent in current access
   xfer_size_t      r_xfer_size;
   bus_size_t       r_bus_size;
   logic [1:0]      num_access;      // Access count minus one
   logic            r_last_done;     // Final access just ended

   // ------------------------------------------------------------------------
   // Sizes, held for the whole transfer
   // ------------------------------------------------------------------------

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
      begin
         r_xfer_size <= XSIZ_8;
         r_bus_size  <= BSIZ_8;
      end
      else if (valid_access)
      begin
         r_xfer_size <= xfer_size;
         r_bus_size  <= bus_size;
      end
   end

   // Straight through in the strobe cycle
   assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;
   assign v_bus_size  = valid_access ? bus_size  : r_bus_size;

   // Transfer bytes over bus bytes, less one
   always_comb
   begin
      case ({v_xfer_size, v_bus_size})
         {XSIZ_32, BSIZ_8}  : num_access = 2'd3;
         {XSIZ_32, BSIZ_16} : num_access = 2'd1;
         {XSIZ_16, BSIZ_8}  : num_access = 2'd1;
         default            : num_access = 2'd0;   // Bus wide enough
      endcase
   end

   // ------------------------------------------------------------------------
   // Wait states and access counter
   // ------------------------------------------------------------------------

   assign smc_done = (r_state == SMC_RW) && (r_wait_cnt == WS_LAST);

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
      begin
         r_wait_cnt   <= '0;
         r_num_access <= 2'd0;
         r_last_done  <= 1'b0;
      end
      else
      begin
         if ((r_state == SMC_RW) && !smc_done)
            r_wait_cnt <= r_wait_cnt + 1'b1;
         else
            r_wait_cnt <= '0;             // Fresh count for next access

         if (valid_access && cs)
            r_num_access <= num_access;
         else if (smc_done && (r_num_access != 2'd0))
            r_num_access <= r_num_access - 2'd1;

         r_last_done <= smc_done && (r_num_access == 2'd0);
      end
   end

   // ------------------------------------------------------------------------
   // State machine
   // ------------------------------------------------------------------------

   always_comb
   begin
      case (r_state)
         SMC_IDLE : smc_nextstate = (valid_access && cs) ? SMC_RW : SMC_IDLE;
         SMC_RW   :
            if (smc_done)
               smc_nextstate = (r_num_access == 2'd0) ? SMC_IDLE : SMC_TURN;
            else
               smc_nextstate = SMC_RW;
         SMC_TURN : smc_nextstate = SMC_RW;  // Chip select high for one cycle
         default  : smc_nextstate = SMC_IDLE;
      endcase
   end

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
         r_state <= SMC_IDLE;
      else
         r_state <= smc_nextstate;
   end

   // High until the xfer_done cycle has passed
   assign busy = (r_state != SMC_IDLE) || r_last_done;

endmodule

`default_nettype wire

//--- design/smc_addr.sv
// External address, chip select and byte enable generation for each access
`default_nettype none

module smc_addr
(
   input  wire                     sys_clk29,
   input  wire                     n_sys_reset29,
   input  wire                     valid_access,   // Start of a host transfer
   input  wire  [1:0]              r_num_access,   // Accesses still to come
   input  smc_pkg::bus_size_t      v_bus_size,
   input  smc_pkg::xfer_size_t     v_xfer_size,
   input  wire                     cs,             // Chip select from host
   input  wire  [31:0]             addr,           // Host address
   input  wire                     smc_done,       // Access complete
   input  smc_pkg::smc_state_e     smc_nextstate,
   output logic [31:0]             smc_addr,
   output logic [3:0]              smc_n_be,
   output logic                    smc_n_cs,
   output logic [3:0]              n_be            // Unregistered byte enables
);

   import smc_pkg::*;

   logic       r_cs;       // Stored chip select
   logic       v_cs;       // Validated chip select
   logic [1:0] r_addr;     // Stored low address bits
   logic [1:0] v_addr;     // Validated low address bits

   // ------------------------------------------------------------------------
   // Chip select and low address store
   // ------------------------------------------------------------------------

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
      begin
         r_cs   <= 1'b0;
         r_addr <= 2'b00;
      end
      else if (valid_access)
      begin
         r_cs   <= cs;
         r_addr <= addr[1:0];
      end
   end

   // Live values in the strobe cycle, stored ones after it
   assign v_cs   = valid_access ? cs        : r_cs;
   assign v_addr = valid_access ? addr[1:0] : r_addr;

   // ------------------------------------------------------------------------
   // External address
   // ------------------------------------------------------------------------

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
         smc_addr <= 32'h0;
      else if (valid_access && cs)
      begin
         // First access takes the highest lane, stepping down from there
         smc_addr[31:2] <= addr[31:2];
         case ({v_xfer_size, v_bus_size})
            {XSIZ_32, BSIZ_32} : smc_addr[1:0] <= 2'b00;
            {XSIZ_32, BSIZ_16} : smc_addr[1:0] <= 2'b10;       // Upper half first
            {XSIZ_32, BSIZ_8}  : smc_addr[1:0] <= 2'b11;       // Byte 3 first
            {XSIZ_16, BSIZ_32} : smc_addr[1:0] <= {addr[1], 1'b0};
            {XSIZ_16, BSIZ_16} : smc_addr[1:0] <= {addr[1], 1'b0};
            {XSIZ_16, BSIZ_8}  : smc_addr[1:0] <= {addr[1], 1'b1};
            default            : smc_addr[1:0] <= addr[1:0];   // Byte transfers
         endcase
      end
      else if (smc_done && (r_num_access != 2'd0))
      begin
         // Next lane down, upper bits held
         case ({v_xfer_size, v_bus_size})
            {XSIZ_32, BSIZ_16} : smc_addr[1:0] <= 2'b00;
            {XSIZ_32, BSIZ_8}  :
               case (r_num_access)
                  2'b11   : smc_addr[1:0] <= 2'b10;
                  2'b10   : smc_addr[1:0] <= 2'b01;
                  default : smc_addr[1:0] <= 2'b00;
               endcase
            {XSIZ_16, BSIZ_8}  : smc_addr[1:0] <= {r_addr[1], 1'b0};
            default            : smc_addr[1:0] <= smc_addr[1:0]; // Single access
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Chip select output
   // ------------------------------------------------------------------------

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
         smc_n_cs <= 1'b1;
      else if (smc_nextstate == SMC_RW)
         smc_n_cs <= ~v_cs;
      else
         smc_n_cs <= 1'b1;                  // Idle and turnaround
   end

   // ------------------------------------------------------------------------
   // Byte enables, little endian lanes
   // ------------------------------------------------------------------------

   always_comb
   begin
      if (v_cs)
      begin
         casez ({v_xfer_size, v_bus_size, v_addr})
            {XSIZ_8,  BSIZ_8,  2'b??} : n_be = 4'b1110;   // Any byte on B0
            {XSIZ_8,  BSIZ_16, 2'b?0} : n_be = 4'b1110;   // Even byte on B0
            {XSIZ_8,  BSIZ_16, 2'b?1} : n_be = 4'b1101;   // Odd byte on B1
            {XSIZ_8,  BSIZ_32, 2'b00} : n_be = 4'b1110;
            {XSIZ_8,  BSIZ_32, 2'b01} : n_be = 4'b1101;
            {XSIZ_8,  BSIZ_32, 2'b10} : n_be = 4'b1011;
            {XSIZ_8,  BSIZ_32, 2'b11} : n_be = 4'b0111;
            {XSIZ_16, BSIZ_8,  2'b??} : n_be = 4'b1110;   // One byte per access
            {XSIZ_16, BSIZ_16, 2'b??} : n_be = 4'b1100;
            {XSIZ_16, BSIZ_32, 2'b0?} : n_be = 4'b1100;   // Lower half
            {XSIZ_16, BSIZ_32, 2'b1?} : n_be = 4'b0011;   // Upper half
            {XSIZ_32, BSIZ_8,  2'b??} : n_be = 4'b1110;
            {XSIZ_32, BSIZ_16, 2'b??} : n_be = 4'b1100;
            {XSIZ_32, BSIZ_32, 2'b??} : n_be = 4'b0000;   // Whole word
            default                   : n_be = 4'b1111;   // Invalid size code
         endcase
      end
      else
         n_be = 4'b1111;
   end

   // Registered enables follow the next state
   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
         smc_n_be <= 4'hF;
      else if (smc_nextstate == SMC_RW)
         smc_n_be <= n_be;
      else
         smc_n_be <= 4'hF;
   end

endmodule

`default_nettype wire

//--- design/smc_data_lanes.sv
// Write lane steering, write enable, read word gathering and transfer done
`default_nettype none

module smc_data_lanes
(
   input  wire                     sys_clk29,
   input  wire                     n_sys_reset29,
   input  wire                     valid_access,   // Start of a host transfer
   input  wire                     write,          // Host write flag
   input  wire  [31:0]             wdata,          // Host write data
   input  smc_pkg::bus_size_t      v_bus_size,
   input  wire  [1:0]              smc_addr_lsb,   // Current external lane
   input  smc_pkg::smc_state_e     smc_nextstate,
   input  wire                     smc_done,
   input  wire  [1:0]              r_num_access,
   input  wire  [31:0]             smc_rdata,      // Data from memory
   output logic [31:0]             smc_wdata,
   output logic                    smc_n_we,
   output logic [31:0]             rdata,          // Gathered read word
   output logic                    xfer_done
);

   import smc_pkg::*;

   logic        r_write;       // Write flag for this transfer
   logic        v_write;
   logic [31:0] r_wdata;       // Write data for this transfer

   assign v_write = valid_access ? write : r_write;

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
         r_write <= 1'b0;
      else if (valid_access)
         r_write <= write;
   end

   always_ff @(posedge sys_clk29)
   begin
      if (valid_access)
         r_wdata <= wdata;
   end

   // ------------------------------------------------------------------------
   // Write path
   // ------------------------------------------------------------------------

   // Lane picked by the registered low address bits
   always_comb
   begin
      case (v_bus_size)
         BSIZ_8  : smc_wdata = {24'h0, r_wdata[8*smc_addr_lsb +: 8]};
         BSIZ_16 : smc_wdata = {16'h0, r_wdata[16*smc_addr_lsb[1] +: 16]};
         default : smc_wdata = r_wdata;    // 32 bit bus, enables pick bytes
      endcase
   end

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
         smc_n_we <= 1'b1;
      else
         smc_n_we <= ~((smc_nextstate == SMC_RW) && v_write);
   end

   // ------------------------------------------------------------------------
   // Read path and completion
   // ------------------------------------------------------------------------

   // Sample returned lanes at the end of each read access
   always_ff @(posedge sys_clk29)
   begin
      if (smc_done && !r_write)
      begin
         case (v_bus_size)
            BSIZ_8  : rdata[8*smc_addr_lsb +: 8]       <= smc_rdata[7:0];
            BSIZ_16 : rdata[16*smc_addr_lsb[1] +: 16]  <= smc_rdata[15:0];
            default : rdata                            <= smc_rdata;
         endcase
      end
   end

   always_ff @(posedge sys_clk29 or negedge n_sys_reset29)
   begin
      if (!n_sys_reset29)
         xfer_done <= 1'b0;
      else
         xfer_done <= smc_done && (r_num_access == 2'd0);  // Last access ended
   end

endmodule

`default_nettype wire

//--- design/smc_top.sv
// Static memory controller top, joining access FSM, address and data lanes
`default_nettype none

module smc_top
#(
   parameter int WAIT_STATES = 1                   // Extra cycles per access
)
(
   input  wire                     sys_clk29,
   input  wire                     n_sys_reset29,
   input  smc_pkg::smc_req_t       req,            // Host transfer request
   input  smc_pkg::bus_size_t      bus_size,       // Static memory width
   input  wire  [31:0]             smc_rdata,      // Read data from memory
   output smc_pkg::smc_ext_t       ext,            // External memory bus
   output logic                    busy,
   output logic                    xfer_done,
   output logic [31:0]             rdata
);

   import smc_pkg::*;

   // ------------------------------------------------------------------------
   // Internal connections
   // ------------------------------------------------------------------------

   smc_state_e  smc_nextstate;
   logic        smc_done;
   logic [1:0]  r_num_access;
   xfer_size_t  v_xfer_size;
   bus_size_t   v_bus_size;
   logic [31:0] ext_addr;
   logic [3:0]  ext_n_be;
   logic        ext_n_cs;
   logic        ext_n_we;
   logic [31:0] ext_wdata;

   assign ext = '{smc_addr  : ext_addr,
                  smc_n_be  : ext_n_be,
                  smc_n_cs  : ext_n_cs,
                  smc_n_we  : ext_n_we,
                  smc_wdata : ext_wdata};

   smc_access_ctrl #(.WAIT_STATES(WAIT_STATES)) i_access_ctrl
   (
      .sys_clk29, .n_sys_reset29,
      .valid_access (req.valid_access), .cs (req.cs),
      .xfer_size (req.xfer_size), .bus_size,
      .smc_nextstate, .smc_done, .r_num_access,
      .v_xfer_size, .v_bus_size, .busy
   );

   smc_addr i_addr
   (
      .sys_clk29, .n_sys_reset29,
      .valid_access (req.valid_access), .r_num_access, .v_bus_size,
      .v_xfer_size, .cs (req.cs), .addr (req.addr), .smc_done, .smc_nextstate,
      .smc_addr (ext_addr), .smc_n_be (ext_n_be), .smc_n_cs (ext_n_cs),
      .n_be ()                                     // Lanes come from address
   );

   smc_data_lanes i_data_lanes
   (
      .sys_clk29, .n_sys_reset29,
      .valid_access (req.valid_access), .write (req.write), .wdata (req.wdata),
      .v_bus_size, .smc_addr_lsb (ext_addr[1:0]), .smc_nextstate, .smc_done,
      .r_num_access, .smc_rdata,
      .smc_wdata (ext_wdata), .smc_n_we (ext_n_we), .rdata, .xfer_done
   );

endmodule

`default_nettype wire

//--- verification/smc_tb.sv
// Testbench for smc_top with clock, reset, file driven transfers, memory model and checks
`default_nettype none

module smc_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import smc_pkg::*;

   localparam int WAIT_STATES = 1;       // Same as the smc_top default
   localparam int MAX_TESTS   = 64;

   logic              sys_clk29 = 1'b0;
   logic              n_sys_reset29;
   smc_req_t          req;
   bus_size_t         bus_size;
   logic [31:0]       smc_rdata;
   smc_ext_t          ext;
   logic              busy;
   logic              xfer_done;
   logic [31:0]       rdata;

   logic [7:0]        mem [0:255];       // Byte wide memory model
   logic [31:0]       t_op    [0:MAX_TESTS-1];
   logic [31:0]       t_xsize [0:MAX_TESTS-1];
   logic [31:0]       t_bsize [0:MAX_TESTS-1];
   logic [31:0]       t_addr  [0:MAX_TESTS-1];
   logic [31:0]       t_wdata [0:MAX_TESTS-1];
   logic [31:0]       t_rdata [0:MAX_TESTS-1];
   int                num_tests;
   int                errors;
   int                failed_tests;
   int unsigned       cycle_cnt;
   int unsigned       cycle_limit;       // 0 until the file is read

   smc_top #(.WAIT_STATES(WAIT_STATES)) i_dut
   (
      .sys_clk29, .n_sys_reset29, .req, .bus_size, .smc_rdata,
      .ext, .busy, .xfer_done, .rdata
   );

   always
   begin
      #4 sys_clk29 = ~sys_clk29;         // 8 ns period
   end

   // Bytes in a size code of either kind
   function automatic int size_bytes(input logic [1:0] code);
      int n;
      case (code)
         2'd0    : n = 1;
         2'd1    : n = 2;
         default : n = 4;
      endcase
      return n;
   endfunction

   // ------------------------------------------------------------------------
   // Memory model with lanes from the bus aligned base upward
   // ------------------------------------------------------------------------

   always_comb
   begin
      int         w;
      logic [7:0] base;
      w = size_bytes(bus_size);
      base = ext.smc_addr[7:0] & ~8'(w - 1);
      smc_rdata = '0;
      for (int k = 0; k < 4; k++)
         if (k < w)
            smc_rdata[8*k +: 8] = mem[base + 8'(k)];
   end

   always @(posedge sys_clk29)
   begin
      int         w;
      logic [7:0] base;
      w = size_bytes(bus_size);
      base = ext.smc_addr[7:0] & ~8'(w - 1);
      if (n_sys_reset29 && !ext.smc_n_cs && !ext.smc_n_we)
         for (int k = 0; k < 4; k++)
            if ((k < w) && !ext.smc_n_be[k])
               mem[base + 8'(k)] <= ext.smc_wdata[8*k +: 8];   // Enabled lanes only
   end

   // Run limit
   always @(posedge sys_clk29)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit))
      begin
         $display("Timeout: the DUT did not finish its transfers within %0d cycles",
                  cycle_limit);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
      if (actual !== expected)
      begin
         $display("[FAIL] %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
         errors++;
      end
   endtask

   // ------------------------------------------------------------------------
   // Stimulus file
   // ------------------------------------------------------------------------

   task automatic load_tests(output bit ok);
      int    fd;
      int    cnt;
      string line;
      ok = 1'b0;
      num_tests = 0;
      fd = $fopen("verification/smc_tests.txt", "r");
      if (fd != 0)
      begin
         while (!$feof(fd) && (num_tests < MAX_TESTS))
         begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() > 0) && (line.getc(0) != "#"))   // Skip comments
            begin
               cnt = $sscanf(line, "%h %h %h %h %h %h", t_op[num_tests],
                             t_xsize[num_tests], t_bsize[num_tests], t_addr[num_tests],
                             t_wdata[num_tests], t_rdata[num_tests]);
               if (cnt == 6)
                  num_tests++;
            end
         end
         $fclose(fd);
         ok = (num_tests > 0);
      end
   endtask

   task automatic check_reset_state();
      @(negedge sys_clk29);
      compare_values(32'(ext.smc_n_cs), 32'd1, "chip select after reset");
      compare_values(32'(ext.smc_n_be), 32'hF, "byte enables after reset");
      compare_values(32'(ext.smc_n_we), 32'd1, "write enable after reset");
      compare_values(ext.smc_addr, 32'h0, "address after reset");
      compare_values(32'(busy), 32'd0, "busy after reset");
      compare_values(32'(xfer_done), 32'd0, "xfer_done after reset");
   endtask

   // ------------------------------------------------------------------------
   // One transfer with its chip select spans and results
   // ------------------------------------------------------------------------

   task automatic run_transfer(input int t);
      smc_req_t    r;
      int          nb;
      int          wb;
      int          nacc;
      int          spans;
      int          run;
      int          gap;
      int          lane;
      int          errs_before;
      logic [31:0] start;
      logic [31:0] exp_addr;
      logic [31:0] mask;
      logic [3:0]  exp_be;
      logic        in_span;
      logic        done;

      nb = size_bytes(t_xsize[t][1:0]);
      wb = size_bytes(t_bsize[t][1:0]);
      nacc = (nb > wb) ? nb / wb : 1;
      start = t_addr[t] & ~32'(nb - 1);                     // Aligned transfer address
      if (nb > wb)
         exp_be = ~4'((1 << wb) - 1);                       // Low lanes of the bus
      else
         exp_be = ~4'(((1 << nb) - 1) << (int'(start[1:0]) % wb));
      errs_before = errors;

      @(negedge sys_clk29);
      while (busy)
         @(negedge sys_clk29);
      r = '0;
      r.valid_access = 1'b1;
      r.write        = t_op[t][0];
      r.cs           = 1'b1;
      r.xfer_size    = xfer_size_t'(t_xsize[t][1:0]);
      r.addr         = t_addr[t];
      r.wdata        = t_wdata[t];
      @(posedge sys_clk29);
      bus_size <= bus_size_t'(t_bsize[t][1:0]);
      req      <= r;
      @(posedge sys_clk29);
      req.valid_access <= 1'b0;                             // One cycle strobe

      spans = 0;
      run = 0;
      gap = 0;
      in_span = 1'b0;
      done = 1'b0;
      while (!done)
      begin
         @(negedge sys_clk29);
         compare_values(32'(busy), 32'd1, "busy during transfer");
         if (!ext.smc_n_cs)
         begin
            if (!in_span)
            begin
               if (spans > 0)
                  compare_values(32'(gap), 32'd1, "idle cycles between accesses");
               spans++;
               run = 0;
               in_span = 1'b1;
            end
            run++;
            // Lanes descend from the highest
            exp_addr = {t_addr[t][31:2], 2'(int'(start[1:0]) + (nacc - spans) * wb)};
            compare_values(ext.smc_addr, exp_addr, "external address");
            compare_values(32'(ext.smc_n_be), 32'(exp_be), "byte enables");
            compare_values(32'(ext.smc_n_we), t_op[t][0] ? 32'd0 : 32'd1, "write enable");
         end
         else
         begin
            if (in_span)
            begin
               compare_values(32'(run), 32'(WAIT_STATES + 1), "access length");
               in_span = 1'b0;
               gap = 0;
            end
            gap++;
         end
         if (xfer_done)
            done = 1'b1;
      end
      compare_values(32'(spans), 32'(nacc), "number of accesses");

      mask = '0;
      for (int k = 0; k < nb; k++)
      begin
         lane = (int'(start[1:0]) + k) & 3;
         mask[8*lane +: 8] = 8'hFF;
         if (t_op[t][0])
            compare_values(32'(mem[start[7:0] + 8'(k)]), 32'(t_wdata[t][8*lane +: 8]),
                           "memory byte after write");
      end
      if (!t_op[t][0])
         compare_values(rdata & mask, t_rdata[t] & mask, "read data");

      if (errors != errs_before)
         failed_tests++;
      $display("test %0d: %s size %0d bus %0d addr %h %s", t, t_op[t][0] ? "write" : "read",
               nb, wb, t_addr[t], (errors == errs_before) ? "ok" : "FAILED");
   endtask

   initial
   begin
      bit ok;
      errors = 0;
      failed_tests = 0;
      cycle_cnt = 0;
      cycle_limit = 0;
      n_sys_reset29 = 1'b0;
      req = '0;
      bus_size = BSIZ_8;
      for (int i = 0; i < 256; i++)
         mem[i] = ~8'(i);                                   // Inverted address pattern

      load_tests(ok);
      if (!ok)
      begin
         $display("Could not read any transfer from verification/smc_tests.txt");
         $display("ERRORS FOUND");
         $finish;
      end
      else
      begin
         cycle_limit = num_tests * (4 * (WAIT_STATES + 2) + 10);
         repeat (2) @(posedge sys_clk29);
         n_sys_reset29 <= 1'b1;
         check_reset_state();
         for (int t = 0; t < num_tests; t++)
            run_transfer(t);
         $display("tests run %0d, tests failed %0d, checks failed %0d",
                  num_tests, failed_tests, errors);
         if (errors == 0)
            $display("NO ERRORS");
         else
            $display("ERRORS FOUND");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- verification/smc_tests.txt
# op (0 read, 1 write)  xfer_size (0 byte 1 half 2 word)  bus_size (0 8b 1 16b 2 32b)
# address  write_data  expected_read_data   (hex, bytes on their address lanes)
0 2 2 10000040 00000000 BCBDBEBF
0 2 1 10000044 00000000 B8B9BABB
0 2 0 10000048 00000000 B4B5B6B7
0 1 2 1000004E 00000000 B0B10000
0 1 1 10000050 00000000 0000AEAF
0 1 0 10000056 00000000 A8A90000
0 0 2 10000059 00000000 0000A600
0 0 1 1000005B 00000000 A4000000
0 0 0 1000005E 00000000 00A10000
1 2 2 20000080 11223344 00000000
1 2 1 20000084 55667788 00000000
1 2 0 20000088 99AABBCC 00000000
1 1 2 2000008E DDEE0000 00000000
1 1 1 20000090 0000F00D 00000000
1 1 0 20000096 BEEF0000 00000000
1 0 2 20000099 00005A00 00000000
1 0 1 2000009B C3000000 00000000
1 0 0 2000009E 003C0000 00000000
0 2 0 20000080 00000000 11223344
0 1 1 2000008E 00000000 DDEE0000
0 0 2 2000009B 00000000 C3000000
0 2 1 20000088 00000000 99AABBCC

//--- flist.f
design/smc_pkg.sv
design/smc_access_ctrl.sv
design/smc_addr.sv
design/smc_data_lanes.sv
design/smc_top.sv
verification/smc_tb.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing
TOP   = smc_tb
FLIST = flist.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
